// ==== Makefile ====
VERILATOR ?= verilator
TOP       := pipe_tb
FILELIST  := compile.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
hw/pipe_pkg.sv
hw/mem_wb_if.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/reg_file.sv
hw/pipe_top.sv
dv/pipe_props.sv
dv/pipe_tb.sv

// ==== dv/pipe_props.sv ====
`default_nettype none

module pipe_props (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic block,       // registered load still waiting
    input wire logic wr_en,
    input wire logic error,
    input wire logic done
);
    timeunit 1ns;
    timeprecision 100ps;

    no_write_while_blocked: assert property (
        @(posedge clk) disable iff (!rst_n) block |-> !wr_en
    ) else $error("wr_en high while block is high");

    no_write_on_error: assert property (
        @(posedge clk) disable iff (!rst_n) !(wr_en && error)
    ) else $error("wr_en high together with error");

    // registers settle one edge into reset
    quiet_in_reset: assert property (
        @(posedge clk) !rst_n |=> (!done && !error)
    ) else $error("done or error high during reset");

endmodule

bind wb_stage pipe_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .block (mwb.block),
    .wr_en (wr_en),
    .error (error),
    .done  (done)
);

`default_nettype wire

// ==== dv/pipe_tb.sv ====
`default_nettype none

module pipe_tb
    import pipe_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          XLEN     = 64;
    localparam int          NUM_ROWS = 15;
    localparam int          LIMIT    = NUM_ROWS * 10 + 50;
    localparam [XLEN-1:0]   MEM_KEY  = 64'h5a5a_0f0f_c3c3_9696;  // data = addr ^ key
    localparam [XLEN-1:0]   ERR_ADDR = 64'h0000_0000_0000_0400;  // answered with rerror

    typedef struct {
        string                 name;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [XLEN-1:0]       exp;
        bit                    chain;     // next row follows without settling
        bit                    exp_err;
        bit                    exp_done;
    } row_t;

    logic clk, rst_n, in_valid, mem_req, mem_rvalid, mem_rerror, busy, done, error;
    op_e                   in_op;
    logic [REG_ADDR_W-1:0] in_rd, rs_addr;
    logic [XLEN-1:0]       in_a, in_b, mem_addr, mem_rdata, rs_data;

    row_t rows [NUM_ROWS];
    int   grp [$];
    int   cyc = 0;
    int   last_load_cyc = -10;
    int   n_pass = 0;
    int   n_fail = 0;
    bit   saw_err, saw_done;
    bit   busy_exp;       // a read is out and wb already holds its load
    bit   busy_bad;

    pipe_top #(.XLEN(XLEN)) uut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_op(in_op), .in_rd(in_rd),
        .in_a(in_a), .in_b(in_b), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid), .mem_rerror(mem_rerror),
        .rs_addr(rs_addr), .rs_data(rs_data), .busy(busy), .done(done), .error(error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("timeout: run took more than %0d cycles", LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // level flags sampled mid cycle, busy against the outstanding read
    always @(negedge clk) begin
        if (error) saw_err = 1'b1;
        if (done) saw_done = 1'b1;
        if (rst_n && busy !== busy_exp) busy_bad = 1'b1;
    end

    // memory model, one request at a time, 0..3 cycles late
    initial begin
        int unsigned     wait_cnt;
        int unsigned     age;
        logic [XLEN-1:0] addr;
        wait_cnt = 0;
        age      = 0;
        addr     = '0;
        busy_exp = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            mem_rvalid = 1'b0;
            mem_rerror = 1'b0;
            age++;                              // cycles since the last request
            if (wait_cnt == 0 && mem_req) begin
                addr     = mem_addr;
                age      = 0;
                wait_cnt = $urandom % 4 + 1;    // 1 means answer in the req cycle
            end
            if (wait_cnt != 0) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    mem_rvalid = 1'b1;
                    mem_rdata  = addr ^ MEM_KEY;
                    mem_rerror = (addr == ERR_ADDR);
                end
            end
            // wb has the load from the cycle after req until the answer shows
            busy_exp = (wait_cnt != 0) && (age != 0);
        end
    end

    task automatic set_row(input int i, input string n, input op_e op,
                           input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp,
                           input bit chain, input bit exp_err, input bit exp_done);
        rows[i] = '{n, op, rd, a, b, exp, chain, exp_err, exp_done};
    endtask

    task automatic fill_table();
        set_row(0,  "add_basic",   op_add,  5'd1,  64'd5, 64'd7, 64'd12, 0, 0, 0);
        set_row(1,  "xor_basic",   op_xor,  5'd2,  64'hff00_ff00, 64'h0ff0_0ff0,
                64'hf0f0_f0f0, 0, 0, 0);
        set_row(2,  "add_wrap",    op_add,  5'd3,  '1, 64'd2, 64'd1, 0, 0, 0);
        set_row(3,  "load_a",      op_load, 5'd4,  64'h1000, 64'h20, 64'h1020 ^ MEM_KEY, 0, 0, 0);
        set_row(4,  "load_b",      op_load, 5'd5,  64'h2000, 64'h8, 64'h2008 ^ MEM_KEY, 0, 0, 0);
        // load then three alu ops issued back to back
        set_row(5,  "ld_stall",    op_load, 5'd6,  64'h3000, 64'h0, 64'h3000 ^ MEM_KEY, 1, 0, 0);
        set_row(6,  "add_after",   op_add,  5'd7,  64'd10, 64'd20, 64'd30, 1, 0, 0);
        set_row(7,  "xor_after",   op_xor,  5'd8,  64'hf0, 64'h0f, 64'hff, 1, 0, 0);
        set_row(8,  "add_reuse",   op_add,  5'd9,  64'd3, 64'd4, 64'd7, 0, 0, 0);
        set_row(9,  "x0_write",    op_add,  5'd0,  64'd123, 64'd1, 64'd0, 0, 0, 0);
        set_row(10, "err_prep",    op_add,  5'd10, 64'h55, 64'h0, 64'h55, 0, 0, 0);
        set_row(11, "ld_misalign", op_load, 5'd10, 64'h4000, 64'h3, 64'h55, 0, 1, 0);
        set_row(12, "ld_rerror",   op_load, 5'd10, ERR_ADDR, 64'h0, 64'h55, 0, 1, 0);
        set_row(13, "halt",        op_halt, 5'd0,  64'h0, 64'h0, 64'h0, 1, 0, 1);
        set_row(14, "add_post",    op_add,  5'd11, 64'h100, 64'h200, 64'h300, 0, 0, 0);
    endtask

    // drive one row; a load accepted one edge ago may still raise busy
    task automatic send_row(input int i);
        @(negedge clk);
        while (busy || last_load_cyc == cyc - 1) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_op    = rows[i].op;
        in_rd    = rows[i].rd;
        in_a     = rows[i].a;
        in_b     = rows[i].b;
        if (rows[i].op == op_load) last_load_cyc = cyc;
    endtask

    task automatic settle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        @(posedge clk);         // give busy a chance to rise
        @(negedge clk);
        while (busy) @(negedge clk);
        repeat (3) @(posedge clk);
    endtask

    task automatic check_group();
        bit any_err;
        bit ok;
        any_err = 1'b0;
        foreach (grp[k]) any_err |= rows[grp[k]].exp_err;
        foreach (grp[k]) begin
            int j;
            j       = grp[k];
            ok      = 1'b1;
            @(posedge clk);
            #1;
            rs_addr = rows[j].rd;
            #0.5;
            if (rs_data !== rows[j].exp) begin
                $display("Fail %s: expected %h, got %h", rows[j].name, rows[j].exp, rs_data);
                ok = 1'b0;
            end
            if (rows[j].exp_err && !saw_err) begin
                $display("%s: error flag never went high", rows[j].name);
                ok = 1'b0;
            end
            if (!any_err && saw_err) begin
                $display("%s: error flag went high although no fault was expected",
                         rows[j].name);
                ok = 1'b0;
            end
            if (rows[j].exp_done && !saw_done) begin
                $display("%s: done flag never went high", rows[j].name);
                ok = 1'b0;
            end
            if (busy_bad) begin
                $display("%s: busy did not stay high exactly while a load waited for data",
                         rows[j].name);
                ok = 1'b0;
            end
            if (ok) begin
                $display("ok   %s = %h", rows[j].name, rs_data);
                n_pass++;
            end else begin
                n_fail++;
            end
        end
    endtask

    initial begin
        void'($urandom(84728));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_op = op_add;
        in_rd = '0;
        in_a = '0;
        in_b = '0;
        rs_addr = '0;
        mem_rdata = '0;
        mem_rvalid = 1'b0;
        mem_rerror = 1'b0;
        fill_table();
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (grp.size() == 0) begin
                saw_err  = 1'b0;
                saw_done = 1'b0;
                busy_bad = 1'b0;
            end
            send_row(i);
            grp.push_back(i);
            if (!rows[i].chain) begin
                settle();
                check_group();
                grp.delete();
            end
        end
        $display("%0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mem_stage.sv ====
`default_nettype none

module mem_stage
    import pipe_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  in_valid,
    input  wire op_e                   in_op,
    input  wire logic [REG_ADDR_W-1:0] in_rd,
    input  wire logic [XLEN-1:0]       in_a,
    input  wire logic [XLEN-1:0]       in_b,
    output logic                       mem_req,   // one-cycle read strobe
    output logic [XLEN-1:0]            mem_addr,
    mem_wb_if.producer                 mwb
);

    logic [XLEN-1:0]       sum;
    logic [XLEN-1:0]       alu_res;
    logic                  is_ld;
    logic                  is_halt;
    logic                  misaligned;

    // output registers
    logic                  valid_q;
    logic                  wen_q;
    logic                  ld_q;
    logic                  err_q;
    logic                  done_q;
    logic                  req_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       data_q;

    assign sum     = in_a + in_b;   // shared by add and load address
    assign is_ld   = (in_op == op_load);
    assign is_halt = (in_op == op_halt);

    // doubleword loads only, low three bits must be clear
    assign misaligned = is_ld && (sum[2:0] != 3'b000);

    always_comb begin
        case (in_op)
            op_xor:  alu_res = in_a ^ in_b;
            op_halt: alu_res = '0;       // nothing to carry
            default: alu_res = sum;      // add and load
        endcase
    end

    // control, frozen while wb waits on a load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            wen_q   <= 1'b0;
            ld_q    <= 1'b0;
            err_q   <= 1'b0;
            done_q  <= 1'b0;
            req_q   <= 1'b0;
        end else begin
            // pulse, never repeats across a stall
            req_q <= !mwb.block && in_valid && is_ld;
            if (!mwb.block) begin
                valid_q <= in_valid;
                wen_q   <= in_valid && !is_halt;    // add, xor, load write rd
                ld_q    <= in_valid && is_ld;
                err_q   <= in_valid && misaligned;
                done_q  <= in_valid && is_halt;
            end
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk) begin
        if (!mwb.block && in_valid) begin
            rd_q   <= in_rd;
            data_q <= alu_res;
        end
    end

    assign mem_req  = req_q;
    assign mem_addr = data_q;    // address lives in the data field

    assign mwb.valid   = valid_q;
    assign mwb.wen     = wen_q;
    assign mwb.is_load = ld_q;
    assign mwb.rd      = rd_q;
    assign mwb.data    = data_q;
    assign mwb.error   = err_q;
    assign mwb.done    = done_q;

endmodule

`default_nettype wire

// ==== hw/mem_wb_if.sv ====
`default_nettype none

// memory stage -> writeback stage bundle, block goes the other way
interface mem_wb_if
    import pipe_pkg::*;
#(
    parameter int XLEN = 64
) ();

    logic                  valid;    // bundle holds an instruction
    logic                  wen;      // instruction writes rd
    logic                  is_load;  // data field is an address
    logic [REG_ADDR_W-1:0] rd;       // destination register
    logic [XLEN-1:0]       data;     // alu result or load address
    logic                  error;    // misaligned load
    logic                  done;     // halt marker
    logic                  block;    // wb waiting on load data

    modport producer (
        output valid,
        output wen,
        output is_load,
        output rd,
        output data,
        output error,
        output done,
        input  block
    );

    modport buffer (
        input  valid,
        input  wen,
        input  is_load,
        input  rd,
        input  data,
        input  error,
        input  done,
        output block
    );

endinterface

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // register file geometry
    localparam int REG_ADDR_W = 5;       // one register index
    localparam int NUM_REGS   = 32;      // x0 .. x31

    // instruction opcodes as seen at the pipe input
    typedef enum logic [1:0] {
        op_add  = 2'd0,  // rd = a + b
        op_xor  = 2'd1,  // rd = a ^ b
        op_load = 2'd2,  // rd = mem[a + b]
        op_halt = 2'd3   // end of program, no write
    } op_e;

endpackage

`default_nettype wire

// ==== hw/pipe_top.sv ====
`default_nettype none

module pipe_top
    import pipe_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // instruction strobe, only while busy is low
    input  wire logic                  in_valid,
    input  wire op_e                   in_op,
    input  wire logic [REG_ADDR_W-1:0] in_rd,
    input  wire logic [XLEN-1:0]       in_a,
    input  wire logic [XLEN-1:0]       in_b,
    // data memory
    output logic                       mem_req,
    output logic [XLEN-1:0]            mem_addr,
    input  wire logic [XLEN-1:0]       mem_rdata,
    input  wire logic                  mem_rvalid,
    input  wire logic                  mem_rerror,
    // observation
    input  wire logic [REG_ADDR_W-1:0] rs_addr,
    output logic [XLEN-1:0]            rs_data,
    output logic                       busy,
    output logic                       done,
    output logic                       error
);

    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;

    mem_wb_if #(.XLEN(XLEN)) mwb ();

    mem_stage #(.XLEN(XLEN)) u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_rd    (in_rd),
        .in_a     (in_a),
        .in_b     (in_b),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mwb      (mwb.producer)
    );

    wb_stage #(.XLEN(XLEN)) u_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid),
        .mem_rerror (mem_rerror),
        .mwb        (mwb.buffer),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .done       (done),
        .error      (error)
    );

    reg_file #(.XLEN(XLEN)) u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_addr (rs_addr),
        .rs_data (rs_data)
    );

    assign busy = mwb.block;   // load outstanding, hold off issue

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

module reg_file
    import pipe_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  wr_en,
    input  wire logic [REG_ADDR_W-1:0] wr_addr,
    input  wire logic [XLEN-1:0]       wr_data,
    input  wire logic [REG_ADDR_W-1:0] rs_addr,
    output logic [XLEN-1:0]            rs_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // single write port, x0 is never touched
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // async read, x0 hardwired
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

endmodule

`default_nettype wire

// ==== hw/wb_stage.sv ====
`default_nettype none

module wb_stage
    import pipe_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [XLEN-1:0]       mem_rdata,
    input  wire logic                  mem_rvalid,
    input  wire logic                  mem_rerror,
    mem_wb_if.buffer                   mwb,
    output logic                       wr_en,
    output logic [REG_ADDR_W-1:0]      wr_addr,
    output logic [XLEN-1:0]            wr_data,
    output logic                       done,
    output logic                       error
);

    logic                  wen_q;    // gated by valid on capture
    logic                  ld_q;
    logic                  got_q;    // load data came back early
    logic                  err_q;
    logic                  done_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       data_q;
    logic                  pending;  // registered load still without data
    logic                  early;    // answer arrives before the load is registered

    assign pending = wen_q && ld_q && !got_q;
    assign early   = mwb.valid && mwb.is_load && mem_rvalid && !pending;

    assign mwb.block = pending && !mem_rvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wen_q  <= 1'b0;
            ld_q   <= 1'b0;
            got_q  <= 1'b0;
            err_q  <= 1'b0;
            done_q <= 1'b0;
        end else if (!mwb.block) begin
            wen_q  <= mwb.wen && mwb.valid;
            ld_q   <= mwb.is_load && mwb.valid;
            got_q  <= early;
            err_q  <= mwb.valid && (mwb.error || (early && mem_rerror));
            done_q <= mwb.done && mwb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!mwb.block) begin
            rd_q   <= mwb.rd;
            data_q <= early ? mem_rdata : mwb.data;  // keep an early answer
        end
    end

    // returned data straight through, or the held alu/early value
    assign wr_data = (ld_q && !got_q) ? mem_rdata : data_q;
    assign wr_addr = rd_q;

    assign error = err_q || (pending && mem_rvalid && mem_rerror);
    assign done  = done_q;
    assign wr_en = wen_q && !mwb.block && !error;   // no write on fault

endmodule

`default_nettype wire
